// ==== dv/matrix_scalar_tb.sv ====
`timescale 1ns/1ps

module matrix_scalar_tb;
    import matrix_pkg::*;

    localparam int data_width = default_data_width;
    // rows, cols, scalar, inputs, expected outputs
    localparam int fields_per_case = 3 + 2 * elems;
    localparam int run_cycles = 12;
    localparam int busy_cycles = 8;
    localparam int idle_cycles = 3;

    logic                  clk;
    logic                  reset_n;
    logic                  en;
    dim_t                  r;
    dim_t                  c;
    logic [data_width-1:0] scalar;
    logic [data_width-1:0] data_in [elems];
    dim_t                  r_out;
    dim_t                  c_out;
    logic [data_width-1:0] data_out [elems];
    logic                  busy;

    int fields [$];
    int num_cases;
    int errors;
    int checks;
    bit loaded;

    matrix_scalar #(
        .data_width(data_width)
    ) i_matrix_scalar (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (en),
        .r        (r),
        .c        (c),
        .scalar   (scalar),
        .data_in  (data_in),
        .r_out    (r_out),
        .c_out    (c_out),
        .data_out (data_out),
        .busy     (busy)
    );

    always #4 clk = ~clk;

    task automatic check_value(string name, int got, int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("error at %0t ns: %s got %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_zero_outputs();
        check_value("r_out", int'(r_out), 0);
        check_value("c_out", int'(c_out), 0);
        for (int k = 0; k < elems; k++) begin
            check_value($sformatf("data_out[%0d]", k), int'(data_out[k]), 0);
        end
    endtask

    task automatic check_result(int base);
        check_value("r_out", int'(r_out), fields[base]);
        check_value("c_out", int'(c_out), fields[base+1]);
        for (int k = 0; k < elems; k++) begin
            check_value($sformatf("data_out[%0d]", k), int'(data_out[k]),
                        fields[base+3+elems+k]);
        end
    endtask

    // decimal tokens of one line appended to fields
    task automatic parse_line(string line);
        int value;
        bit in_num;
        byte ch;
        value = 0;
        in_num = 1'b0;
        for (int k = 0; k < line.len(); k++) begin
            ch = line[k];
            if (ch >= "0" && ch <= "9") begin
                value = value * 10 + int'(ch) - 48;
                in_num = 1'b1;
            end else if (in_num) begin
                fields.push_back(value);
                value = 0;
                in_num = 1'b0;
            end
        end
        if (in_num) begin
            fields.push_back(value);
        end
    endtask

    task automatic load_vectors();
        int fd;
        int code;
        string line;
        fd = $fopen("dv/matrix_scalar_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dv/matrix_scalar_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // lines starting with # are comments
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    parse_line(line);
                end
            end
            $fclose(fd);
            if (fields.size() % fields_per_case != 0) begin
                errors++;
                $display("vector file holds %0d numbers, not whole cases", fields.size());
            end
            num_cases = fields.size() / fields_per_case;
            if (num_cases == 0) begin
                errors++;
                $display("vector file holds no complete case");
            end
        end
    endtask

    task automatic run_case(int idx);
        int base;
        base = idx * fields_per_case;
        $display("case %0d: %0d x %0d, scalar %0d", idx, fields[base], fields[base+1],
                 fields[base+2]);
        @(posedge clk);
        en <= 1'b1;
        r <= dim_t'(fields[base]);
        c <= dim_t'(fields[base+1]);
        scalar <= data_width'(fields[base+2]);
        for (int k = 0; k < elems; k++) begin
            data_in[k] <= data_width'(fields[base+3+k]);
        end
        for (int k = 1; k <= run_cycles; k++) begin
            @(posedge clk);
            if (k == run_cycles) begin
                en <= 1'b0;
            end
            @(negedge clk);
            check_value("busy", int'(busy), (k <= busy_cycles) ? 1 : 0);
            // nothing visible until the run completes
            if (k <= busy_cycles) begin
                check_zero_outputs();
            end else begin
                check_result(base);
            end
        end
        // en low for idle_cycles edges before the next case raises it
        for (int k = 1; k < idle_cycles; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_value("busy", int'(busy), 0);
            check_zero_outputs();
        end
    endtask

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        en = 1'b0;
        r = '0;
        c = '0;
        scalar = '0;
        for (int k = 0; k < elems; k++) begin
            data_in[k] = '0;
        end
        errors = 0;
        checks = 0;
        num_cases = 0;
        load_vectors();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("busy", int'(busy), 0);
        check_zero_outputs();
        for (int n = 0; n < num_cases; n++) begin
            run_case(n);
        end
        $display("%0d cases, %0d checks, %0d errors", num_cases, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog sized from the cycles of one case plus margin
    initial begin
        int limit_ns;
        wait (loaded);
        limit_ns = num_cases * (run_cycles + idle_cycles) * 8 + 200;
        #(limit_ns);
        $display("timeout: run still going after %0d ns", limit_ns);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== dv/matrix_scalar_vectors.txt ====
# per case: rows cols scalar, then 25 inputs and 25 expected outputs in dense slot order
# a case spans five lines, lines starting with # are comments
5 5 3
1 2 3 4 5 6 7 8 9 10 11 12 13
14 15 16 17 18 19 20 21 22 23 24 25
3 6 9 12 15 18 21 24 27 30 33 36 39
42 45 48 51 54 57 60 63 66 69 72 75
1 1 7
11 50 50 50 50 50 50 50 50 50 50 50 50
50 50 50 50 50 50 50 50 50 50 50 50
77 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0
2 3 10
4 8 15 16 23 42 7 7 7 7 7 7 7
7 7 7 7 7 7 7 7 7 7 7 7
40 80 150 160 230 420 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0
5 2 2
1 3 5 7 9 11 13 15 17 19 200 200 200
200 200 200 200 200 200 200 200 200 200 200 200
2 6 10 14 18 22 26 30 34 38 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0
4 5 5
10 11 12 13 14 15 16 17 18 19 20 21 22
23 24 25 26 27 28 29 300 300 300 300 300
50 55 60 65 70 75 80 85 90 95 100 105 110
115 120 125 130 135 140 145 0 0 0 0 0
5 5 511
511 510 500 400 300 256 255 200 129 128 127 100 64
50 33 17 9 5 3 2 1 0 257 384 448
1 2 12 112 212 256 257 312 383 384 385 412 448
462 479 495 503 507 509 510 511 0 255 128 64

// ==== filelist.f ====
source/matrix_pkg.sv
source/matrix_if.sv
source/matrix_pack.sv
source/row_scaler.sv
source/matrix_unpack.sv
source/matrix_scalar.sv
dv/matrix_scalar_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the matrix_scalar testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f filelist.f --top-module matrix_scalar_tb -o matrix_scalar_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/matrix_scalar_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$log"; then
    echo "simulation failed, see $log"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== source/matrix_if.sv ====
`timescale 1ns/1ps

interface matrix_if #(
    parameter int data_width = matrix_pkg::default_data_width
);
    import matrix_pkg::*;

    // element (i, j) at slot i * dim + j
    logic [data_width-1:0] grid [elems];
    dim_t rows;
    dim_t cols;
    // one-cycle strobe, fields hold until the next one
    logic valid;

    modport src (
        output grid,
        output rows,
        output cols,
        output valid
    );

    modport dst (
        input grid,
        input rows,
        input cols,
        input valid
    );

endinterface

// ==== source/matrix_pack.sv ====
`timescale 1ns/1ps

module matrix_pack #(
    parameter int data_width = matrix_pkg::default_data_width
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    input  matrix_pkg::dim_t      r,
    input  matrix_pkg::dim_t      c,
    input  logic [data_width-1:0] data_in [matrix_pkg::elems],
    matrix_if.src                 grid_out
);
    import matrix_pkg::*;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grid_out.valid <= 1'b0;
        end else begin
            grid_out.valid <= start;
        end
    end

    // dense row-major into fixed 5 wide rows
    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < dim; i++) begin
                for (int j = 0; j < dim; j++) begin
                    if (i < int'(r) && j < int'(c)) begin
                        grid_out.grid[i*dim+j] <= data_in[i*int'(c)+j];
                    end else begin
                        // padding stays zero so its product is zero too
                        grid_out.grid[i*dim+j] <= '0;
                    end
                end
            end
            grid_out.rows <= r;
            grid_out.cols <= c;
        end
    end

endmodule

// ==== source/matrix_pkg.sv ====
package matrix_pkg;

    // grid geometry
    localparam int dim = 5;
    localparam int elems = dim * dim;

    // shape fields and row counter
    localparam int dim_w = 3;

    // element width unless the top level overrides it
    localparam int default_data_width = 9;

    typedef logic [dim_w-1:0] dim_t;

    // top-level run/hold control
    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_run,
        ctrl_hold
    } ctrl_state_t;

    // row scaler sequencing
    typedef enum logic {
        scale_idle,
        scale_rows
    } scale_state_t;

endpackage

// ==== source/matrix_scalar.sv ====
`timescale 1ns/1ps

module matrix_scalar #(
    parameter int data_width = matrix_pkg::default_data_width
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  en,
    input  matrix_pkg::dim_t      r,
    input  matrix_pkg::dim_t      c,
    input  logic [data_width-1:0] scalar,
    input  logic [data_width-1:0] data_in [matrix_pkg::elems],
    output matrix_pkg::dim_t      r_out,
    output matrix_pkg::dim_t      c_out,
    output logic [data_width-1:0] data_out [matrix_pkg::elems],
    output logic                  busy
);
    import matrix_pkg::*;

    ctrl_state_t           state;
    logic                  start;
    logic                  done;
    logic [data_width-1:0] result [elems];
    dim_t                  res_rows;
    dim_t                  res_cols;

    matrix_if #(.data_width(data_width)) packed_grid ();
    matrix_if #(.data_width(data_width)) scaled_grid ();

    // only from idle, so the level gives a single pulse
    assign start = (state == ctrl_idle) && en;
    assign busy = (state == ctrl_run);

    matrix_pack #(
        .data_width(data_width)
    ) i_matrix_pack (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (start),
        .r        (r),
        .c        (c),
        .data_in  (data_in),
        .grid_out (packed_grid.src)
    );

    row_scaler #(
        .data_width(data_width)
    ) i_row_scaler (
        .clk      (clk),
        .reset_n  (reset_n),
        .scalar   (scalar),
        .grid_in  (packed_grid.dst),
        .grid_out (scaled_grid.src)
    );

    matrix_unpack #(
        .data_width(data_width)
    ) i_matrix_unpack (
        .clk      (clk),
        .reset_n  (reset_n),
        .grid_in  (scaled_grid.dst),
        .data_out (result),
        .rows_out (res_rows),
        .cols_out (res_cols),
        .done     (done)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ctrl_idle;
            r_out <= '0;
            c_out <= '0;
            for (int k = 0; k < elems; k++) begin
                data_out[k] <= '0;
            end
        end else begin
            case (state)
                ctrl_idle: begin
                    if (en) begin
                        state <= ctrl_run;
                    end
                end
                // en dropping here does not abort the run
                ctrl_run: begin
                    if (done) begin
                        state <= ctrl_hold;
                        data_out <= result;
                        r_out <= res_rows;
                        c_out <= res_cols;
                    end
                end
                ctrl_hold: begin
                    if (!en) begin
                        state <= ctrl_idle;
                        r_out <= '0;
                        c_out <= '0;
                        for (int k = 0; k < elems; k++) begin
                            data_out[k] <= '0;
                        end
                    end
                end
                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

endmodule

// ==== source/matrix_unpack.sv ====
`timescale 1ns/1ps

module matrix_unpack #(
    parameter int data_width = matrix_pkg::default_data_width
) (
    input  logic                  clk,
    input  logic                  reset_n,
    matrix_if.dst                 grid_in,
    output logic [data_width-1:0] data_out [matrix_pkg::elems],
    output matrix_pkg::dim_t      rows_out,
    output matrix_pkg::dim_t      cols_out,
    output logic                  done
);
    import matrix_pkg::*;

    logic [data_width-1:0] dense [elems];

    // grid back to row-major, tail left at zero
    always_comb begin
        for (int k = 0; k < elems; k++) begin
            dense[k] = '0;
        end
        for (int i = 0; i < dim; i++) begin
            for (int j = 0; j < dim; j++) begin
                if (i < int'(grid_in.rows) && j < int'(grid_in.cols)) begin
                    dense[i*int'(grid_in.cols)+j] = grid_in.grid[i*dim+j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done <= 1'b0;
        end else begin
            done <= grid_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (grid_in.valid) begin
            data_out <= dense;
            rows_out <= grid_in.rows;
            cols_out <= grid_in.cols;
        end
    end

endmodule

// ==== source/row_scaler.sv ====
`timescale 1ns/1ps

module row_scaler #(
    parameter int data_width = matrix_pkg::default_data_width
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [data_width-1:0] scalar,
    matrix_if.dst                 grid_in,
    matrix_if.src                 grid_out
);
    import matrix_pkg::*;

    scale_state_t          state;
    dim_t                  row_cnt;
    logic [data_width-1:0] scalar_q;
    logic                  last_row;
    logic [2*data_width-1:0] prod [dim];

    assign last_row = (row_cnt == dim_t'(dim - 1));

    // five multipliers on the selected row
    always_comb begin
        for (int k = 0; k < dim; k++) begin
            prod[k] = grid_in.grid[int'(row_cnt)*dim+k] * scalar_q;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= scale_idle;
            row_cnt <= '0;
            grid_out.valid <= 1'b0;
        end else begin
            grid_out.valid <= 1'b0;
            case (state)
                scale_idle: begin
                    if (grid_in.valid) begin
                        state <= scale_rows;
                        row_cnt <= '0;
                    end
                end
                scale_rows: begin
                    if (last_row) begin
                        state <= scale_idle;
                        row_cnt <= '0;
                        grid_out.valid <= 1'b1;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= scale_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == scale_idle && grid_in.valid) begin
            scalar_q <= scalar;
        end
        if (state == scale_rows) begin
            // keep only the low bits of each product
            for (int k = 0; k < dim; k++) begin
                grid_out.grid[int'(row_cnt)*dim+k] <= prod[k][data_width-1:0];
            end
            if (last_row) begin
                grid_out.rows <= grid_in.rows;
                grid_out.cols <= grid_in.cols;
            end
        end
    end

endmodule
